// File: design/ddr2_pkg.sv
package ddr2_pkg;

    localparam int ADDR_W    = 25;
    localparam int ROW_W     = 13;
    localparam int BANK_W    = 2;
    localparam int COL_W     = 10;
    localparam int DQ_W      = 16;
    localparam int DM_W      = 2;
    localparam int BURST_LEN = 8;
    localparam int TMR_W     = 6;    // holds the longest wait below

    typedef logic [2:0] cmd_op_t;

    localparam cmd_op_t OP_SCR = 3'd1;    // single-burst read
    localparam cmd_op_t OP_SCW = 3'd2;    // single-burst write

    typedef struct packed {
        logic              is_write;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        logic [ADDR_W-1:0] addr;
    } dcmd_t;

    // {csbar, rasbar, casbar, webar}
    typedef logic [3:0] bus_cmd_t;

    localparam bus_cmd_t BUS_NOP   = 4'b1111;
    localparam bus_cmd_t BUS_ACT   = 4'b0011;
    localparam bus_cmd_t BUS_READ  = 4'b0101;
    localparam bus_cmd_t BUS_WRITE = 4'b0100;
    localparam bus_cmd_t BUS_PRE   = 4'b0010;
    localparam bus_cmd_t BUS_REF   = 4'b0001;

    // each wait lasts its value plus one cycle
    localparam logic [TMR_W-1:0] T_GETCMD        = 6'd2;
    localparam logic [TMR_W-1:0] T_ACTIVATE      = 6'd1;
    localparam logic [TMR_W-1:0] T_READ_WAIT     = 6'd26;
    localparam logic [TMR_W-1:0] T_WRITE_WAIT    = 6'd12;
    localparam logic [TMR_W-1:0] T_WRITE_RECOVER = 6'd17;
    localparam logic [TMR_W-1:0] T_PRE           = 6'd1;
    localparam logic [TMR_W-1:0] T_RNOP          = 6'd7;
    localparam logic [TMR_W-1:0] T_REF           = 6'd1;
    localparam logic [TMR_W-1:0] T_RIDLE         = 6'd55;

    localparam logic [ROW_W-1:0] PRE_ALL_A = 13'h400;    // A10 high, all banks

endpackage

// File: design/dcmd_if.sv
`timescale 1ns/100ps

interface dcmd_if
    import ddr2_pkg::*;
();

    logic push;
    logic full;
    logic pop;
    logic not_empty;
    wire dcmd_t data;    // written by whichever side is upstream of the queue

    modport producer (
        output push,
        output data,
        input  full
    );

    // same view on both sides of the queue; data is an input on the write
    // side and the head entry on the read side
    modport fifo (
        input  push,
        input  pop,
        output full,
        output not_empty,
        inout  data
    );

    modport consumer (
        output pop,
        input  not_empty,
        input  data
    );

endinterface

// File: design/cmd_fetch.sv
`timescale 1ns/100ps

module cmd_fetch
    import ddr2_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready_init_i,
    input  logic              emptybar_cmd_i,
    input  logic [ADDR_W-1:0] addr_cmd_i,
    input  cmd_op_t           cmd_cmd_i,
    output logic              get_cmd_o,
    dcmd_if.producer          dq_o
);

    logic [TMR_W-1:0] wait_cnt;
    logic             busy;
    logic             start;
    logic             sample;
    dcmd_t            cmd_q;

    // hold off until a pending push has shown up in full
    assign start  = ready_init_i && emptybar_cmd_i && !dq_o.full && !busy && !dq_o.push;
    assign sample = busy && (wait_cnt == '0);

    assign dq_o.data = cmd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            get_cmd_o <= 1'b0;
            dq_o.push <= 1'b0;
        end else begin
            get_cmd_o <= start;
            dq_o.push <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                wait_cnt <= T_GETCMD;    // external FIFO read latency
            end else if (sample) begin
                busy      <= 1'b0;
                dq_o.push <= (cmd_cmd_i == OP_SCR) || (cmd_cmd_i == OP_SCW);
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // address split: row 24:12, bank 4:3, column 11:5 and 2:0
    always_ff @(posedge clk) begin
        if (sample) begin
            cmd_q.is_write <= (cmd_cmd_i == OP_SCW);
            cmd_q.bank     <= addr_cmd_i[4:3];
            cmd_q.row      <= addr_cmd_i[24:12];
            cmd_q.col      <= {addr_cmd_i[11:5], addr_cmd_i[2:0]};
            cmd_q.addr     <= addr_cmd_i;
        end
    end

endmodule

// File: design/cmd_queue.sv
`timescale 1ns/100ps

module cmd_queue
    import ddr2_pkg::*;
#(
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic reset,
    dcmd_if.fifo in_i,
    dcmd_if.fifo out_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH + 1);

    dcmd_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic             full;
    logic             not_empty;
    logic             do_push;
    logic             do_pop;

    assign full      = (level == LVL_W'(DEPTH));
    assign not_empty = (level != '0);
    assign do_push   = in_i.push && !full;
    assign do_pop    = out_o.pop && not_empty;

    assign in_i.full       = full;
    assign in_i.not_empty  = not_empty;
    assign out_o.full      = full;
    assign out_o.not_empty = not_empty;
    assign out_o.data      = mem[rd_ptr];    // head entry

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= in_i.data;
    end

endmodule

// File: design/refresh_timer.sv
`timescale 1ns/100ps

module refresh_timer #(
    parameter int REFRESH_INTERVAL = 3900,
    parameter int REFRESH_THRESH   = 100
) (
    input  logic clk,
    input  logic reset,
    input  logic ready_init_i,
    input  logic idle_i,
    input  logic refresh_done_i,
    output logic need_refresh_o
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] count;

    assign need_refresh_o = (count < CNT_W'(REFRESH_THRESH));

    // only idle time counts toward the interval
    always_ff @(posedge clk) begin
        if (reset || refresh_done_i) begin
            count <= CNT_W'(REFRESH_INTERVAL);
        end else if (ready_init_i && idle_i && !need_refresh_o) begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: design/ddr2_sequencer.sv
`timescale 1ns/100ps

module ddr2_sequencer
    import ddr2_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready_init_i,
    input  logic              need_refresh_i,
    dcmd_if.consumer          dc_i,
    input  logic [DQ_W-1:0]   din_data_i,
    output logic              idle_o,
    output logic              refresh_done_o,
    output logic              get_data_o,
    output logic              put_return_o,
    output logic [ADDR_W-1:0] addr_return_o,
    output logic              listen_ring_o,
    output logic [2:0]        read_ptr_ring_o,
    output logic              csbar_o,
    output logic              rasbar_o,
    output logic              casbar_o,
    output logic              webar_o,
    output logic [BANK_W-1:0] ba_o,
    output logic [ROW_W-1:0]  a_o,
    output logic [DQ_W-1:0]   dq_o,
    output logic [DM_W-1:0]   dm_o,
    output logic [1:0]        dqs_o,
    output logic              ts_o
);

    typedef enum logic [3:0] {
        IDLE,
        ACTIVATE,
        ISSUE_READ,
        READ_WAIT,
        READ_RETURN,
        ISSUE_WRITE,
        WRITE_WAIT,
        WRITE_DATA,
        WRITE_RECOVER,
        RPRE,
        RNOP,
        RREF,
        RIDLE
    } state_t;

    localparam int BEAT_W = $clog2(BURST_LEN);

    state_t            state;
    logic [TMR_W-1:0]  cnt;
    logic [BEAT_W-1:0] beat;    // wraps to zero at the end of each burst
    bus_cmd_t          bus_q;
    dcmd_t             cmd_q;
    logic [ROW_W-1:0]  col_a;
    logic              cnt_done;
    logic              take_cmd;
    logic              rd_beat;
    logic              wr_beat;

    assign cnt_done = (cnt == '0);
    assign take_cmd = (state == IDLE) && ready_init_i && !need_refresh_i && dc_i.not_empty;
    assign rd_beat  = ((state == READ_WAIT) && cnt_done) ||
                      ((state == READ_RETURN) && (beat != '0));
    assign wr_beat  = ((state == WRITE_WAIT) && cnt_done) ||
                      ((state == WRITE_DATA) && (beat != '0));

    // A10 set for auto-precharge, column on A[9:1]
    assign col_a = {2'b00, 1'b1, cmd_q.col[8:0], 1'b0};

    assign {csbar_o, rasbar_o, casbar_o, webar_o} = bus_q;
    assign idle_o         = (state == IDLE);
    assign refresh_done_o = (state == RIDLE) && cnt_done;
    assign dm_o           = '0;    // full words only

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= IDLE;
            cnt             <= '0;
            beat            <= '0;
            bus_q           <= BUS_NOP;
            ba_o            <= '0;
            a_o             <= '0;
            dqs_o           <= '0;
            ts_o            <= 1'b0;
            get_data_o      <= 1'b0;
            put_return_o    <= 1'b0;
            listen_ring_o   <= 1'b0;
            read_ptr_ring_o <= '0;
            dc_i.pop        <= 1'b0;
        end else begin
            bus_q         <= BUS_NOP;
            dc_i.pop      <= take_cmd;
            put_return_o  <= rd_beat;
            listen_ring_o <= rd_beat && (beat == '0);
            get_data_o    <= wr_beat;
            ts_o          <= wr_beat;
            if (!cnt_done)
                cnt <= cnt - 1'b1;
            if (rd_beat) begin
                read_ptr_ring_o <= beat;
                beat            <= beat + 1'b1;
            end
            if (wr_beat) begin
                dqs_o <= ~dqs_o;
                beat  <= beat + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (ready_init_i && need_refresh_i) begin    // refresh wins
                        bus_q <= BUS_PRE;
                        a_o   <= PRE_ALL_A;
                        cnt   <= T_PRE;
                        state <= RPRE;
                    end else if (take_cmd) begin
                        bus_q <= BUS_ACT;
                        ba_o  <= dc_i.data.bank;
                        a_o   <= dc_i.data.row;
                        cnt   <= T_ACTIVATE;
                        state <= ACTIVATE;
                    end
                end
                ACTIVATE: begin
                    if (!cnt_done) begin
                        bus_q <= BUS_ACT;
                    end else begin
                        bus_q <= cmd_q.is_write ? BUS_WRITE : BUS_READ;
                        a_o   <= col_a;
                        state <= cmd_q.is_write ? ISSUE_WRITE : ISSUE_READ;
                    end
                end
                ISSUE_READ: begin
                    cnt   <= T_READ_WAIT;
                    state <= READ_WAIT;
                end
                READ_WAIT: if (cnt_done) state <= READ_RETURN;
                READ_RETURN: if (beat == '0) state <= IDLE;
                ISSUE_WRITE: begin
                    cnt   <= T_WRITE_WAIT;
                    state <= WRITE_WAIT;
                end
                WRITE_WAIT: if (cnt_done) state <= WRITE_DATA;
                WRITE_DATA: begin
                    if (beat == '0) begin
                        cnt   <= T_WRITE_RECOVER;    // write recovery before next ACTIVATE
                        state <= WRITE_RECOVER;
                    end
                end
                WRITE_RECOVER: if (cnt_done) state <= IDLE;
                RPRE: begin
                    if (!cnt_done) begin
                        bus_q <= BUS_PRE;
                    end else begin
                        cnt   <= T_RNOP;
                        state <= RNOP;
                    end
                end
                RNOP: begin
                    if (cnt_done) begin
                        bus_q <= BUS_REF;
                        cnt   <= T_REF;
                        state <= RREF;
                    end
                end
                RREF: begin
                    if (!cnt_done) begin
                        bus_q <= BUS_REF;
                    end else begin
                        cnt   <= T_RIDLE;
                        state <= RIDLE;
                    end
                end
                RIDLE: if (cnt_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_cmd)
            cmd_q <= dc_i.data;
        if (rd_beat)
            addr_return_o <= cmd_q.addr + ADDR_W'(beat);
        if (wr_beat)
            dq_o <= din_data_i;
    end

endmodule

// File: design/ddr2_protocol_engine.sv
`timescale 1ns/100ps

module ddr2_protocol_engine
    import ddr2_pkg::*;
#(
    parameter int REFRESH_INTERVAL = 3900,
    parameter int REFRESH_THRESH   = 100
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ready_init_i,
    input  logic [ADDR_W-1:0] addr_cmdfifo_i,
    input  cmd_op_t           cmd_cmdfifo_i,
    input  logic              emptybar_cmdfifo_i,
    input  logic [DQ_W-1:0]   din_datafifo_i,
    output logic              get_cmdfifo_o,
    output logic              get_datafifo_o,
    output logic              put_returnfifo_o,
    output logic [ADDR_W-1:0] addr_returnfifo_o,
    output logic              listen_ringbuff_o,
    output logic [2:0]        readptr_ringbuff_o,
    output logic              csbar_o,
    output logic              rasbar_o,
    output logic              casbar_o,
    output logic              webar_o,
    output logic [BANK_W-1:0] ba_o,
    output logic [ROW_W-1:0]  a_o,
    output logic [DQ_W-1:0]   dq_sstl_o,
    output logic [DM_W-1:0]   dm_sstl_o,
    output logic [1:0]        dqs_sstl_o,
    output logic              ts_o
);

    logic need_refresh;
    logic seq_idle;
    logic refresh_done;

    dcmd_if fetch_if ();    // fetch -> queue
    dcmd_if seq_if ();      // queue -> sequencer

    cmd_fetch u_cmd_fetch (
        .clk            (clk),
        .reset          (reset),
        .ready_init_i   (ready_init_i),
        .emptybar_cmd_i (emptybar_cmdfifo_i),
        .addr_cmd_i     (addr_cmdfifo_i),
        .cmd_cmd_i      (cmd_cmdfifo_i),
        .get_cmd_o      (get_cmdfifo_o),
        .dq_o           (fetch_if.producer)
    );

    cmd_queue #(
        .DEPTH (2)
    ) u_cmd_queue (
        .clk   (clk),
        .reset (reset),
        .in_i  (fetch_if.fifo),
        .out_o (seq_if.fifo)
    );

    refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .REFRESH_THRESH   (REFRESH_THRESH)
    ) u_refresh_timer (
        .clk            (clk),
        .reset          (reset),
        .ready_init_i   (ready_init_i),
        .idle_i         (seq_idle),
        .refresh_done_i (refresh_done),
        .need_refresh_o (need_refresh)
    );

    ddr2_sequencer u_ddr2_sequencer (
        .clk             (clk),
        .reset           (reset),
        .ready_init_i    (ready_init_i),
        .need_refresh_i  (need_refresh),
        .dc_i            (seq_if.consumer),
        .din_data_i      (din_datafifo_i),
        .idle_o          (seq_idle),
        .refresh_done_o  (refresh_done),
        .get_data_o      (get_datafifo_o),
        .put_return_o    (put_returnfifo_o),
        .addr_return_o   (addr_returnfifo_o),
        .listen_ring_o   (listen_ringbuff_o),
        .read_ptr_ring_o (readptr_ringbuff_o),
        .csbar_o         (csbar_o),
        .rasbar_o        (rasbar_o),
        .casbar_o        (casbar_o),
        .webar_o         (webar_o),
        .ba_o            (ba_o),
        .a_o             (a_o),
        .dq_o            (dq_sstl_o),
        .dm_o            (dm_sstl_o),
        .dqs_o           (dqs_sstl_o),
        .ts_o            (ts_o)
    );

endmodule

// File: verification/ddr2_protocol_engine_checker.sv
`timescale 1ns/100ps

module ddr2_protocol_engine_checker (
    input logic       clk,
    input logic       reset,
    input logic       get_data_i,
    input logic       put_return_i,
    input logic       listen_i,
    input logic       ts_i,
    input logic [1:0] dqs_i
);

    int fail_count;

    initial fail_count = 0;

    // a beat either returns read data or takes write data
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(get_data_i && put_return_i))
        else begin
            $error("get_data and put_return high in the same cycle");
            fail_count++;
        end

    a_ts_with_data: assert property (@(posedge clk) disable iff (reset)
        ts_i == get_data_i)
        else begin
            $error("ts does not follow the write data beats");
            fail_count++;
        end

    a_dqs_toggle: assert property (@(posedge clk) disable iff (reset)
        get_data_i |-> (dqs_i == ~$past(dqs_i)))
        else begin
            $error("dqs did not toggle on a write beat");
            fail_count++;
        end

    a_dqs_hold: assert property (@(posedge clk) disable iff (reset)
        !get_data_i |-> (dqs_i == $past(dqs_i)))
        else begin
            $error("dqs moved outside a write beat");
            fail_count++;
        end

    a_listen_on_return: assert property (@(posedge clk) disable iff (reset)
        listen_i |-> put_return_i)
        else begin
            $error("listen high without a return push");
            fail_count++;
        end

endmodule

bind ddr2_sequencer ddr2_protocol_engine_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .get_data_i   (get_data_o),
    .put_return_i (put_return_o),
    .listen_i     (listen_ring_o),
    .ts_i         (ts_o),
    .dqs_i        (dqs_o)
);

// File: verification/ddr2_protocol_engine_tb.sv
`timescale 1ns/100ps

module ddr2_protocol_engine_tb
    import ddr2_pkg::*;
();

    localparam int MAX_CASES = 32;
    localparam int BEATS     = 8;

    localparam logic [2:0] OPC_READ  = 3'd1;
    localparam logic [2:0] OPC_WRITE = 3'd2;

    // {cs, ras, cas, we}, all low active
    localparam logic [3:0] CMD_NOP   = 4'b1111;
    localparam logic [3:0] CMD_ACT   = 4'b0011;
    localparam logic [3:0] CMD_READ  = 4'b0101;
    localparam logic [3:0] CMD_WRITE = 4'b0100;
    localparam logic [3:0] CMD_PRE   = 4'b0010;
    localparam logic [3:0] CMD_REF   = 4'b0001;

    localparam int EV_ACT    = 0;
    localparam int EV_READ   = 1;
    localparam int EV_WRITE  = 2;
    localparam int EV_PRE    = 3;
    localparam int EV_REF    = 4;
    localparam int EV_RETURN = 5;
    localparam int EV_DATA   = 6;

    logic              clk;
    logic              reset;
    logic              ready_init;
    logic [ADDR_W-1:0] addr_cmd;
    cmd_op_t           cmd_cmd;
    logic              emptybar_cmd;
    logic [DQ_W-1:0]   din_data;
    logic              get_cmd;
    logic              get_data;
    logic              put_return;
    logic [ADDR_W-1:0] addr_return;
    logic              listen;
    logic [2:0]        read_ptr;
    logic              csbar;
    logic              rasbar;
    logic              casbar;
    logic              webar;
    logic [BANK_W-1:0] ba;
    logic [ROW_W-1:0]  a;
    logic [DQ_W-1:0]   dq;
    logic [DM_W-1:0]   dm;
    logic [1:0]        dqs;
    logic              ts;

    cmd_op_t           case_op   [MAX_CASES];
    logic [ADDR_W-1:0] case_addr [MAX_CASES];
    logic [BANK_W-1:0] case_bank [MAX_CASES];
    logic [ROW_W-1:0]  case_row  [MAX_CASES];
    logic [9:0]        case_col  [MAX_CASES];
    logic [DQ_W-1:0]   wr_words  [$];    // data FIFO words taken by the DUT, in order
    int                n_cases;
    int                fetch_idx;
    int                act_count;
    logic [3:0]        prev_bus;
    integer            seed;
    int                errors;
    int                checks;
    int                tests;
    bit                aborted;

    ddr2_protocol_engine #(
        .REFRESH_INTERVAL (400),
        .REFRESH_THRESH   (100)
    ) u_ddr2_protocol_engine (
        .clk                (clk),
        .reset              (reset),
        .ready_init_i       (ready_init),
        .addr_cmdfifo_i     (addr_cmd),
        .cmd_cmdfifo_i      (cmd_cmd),
        .emptybar_cmdfifo_i (emptybar_cmd),
        .din_datafifo_i     (din_data),
        .get_cmdfifo_o      (get_cmd),
        .get_datafifo_o     (get_data),
        .put_returnfifo_o   (put_return),
        .addr_returnfifo_o  (addr_return),
        .listen_ringbuff_o  (listen),
        .readptr_ringbuff_o (read_ptr),
        .csbar_o            (csbar),
        .rasbar_o           (rasbar),
        .casbar_o           (casbar),
        .webar_o            (webar),
        .ba_o               (ba),
        .a_o                (a),
        .dq_sstl_o          (dq),
        .dm_sstl_o          (dm),
        .dqs_sstl_o         (dqs),
        .ts_o               (ts)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [3:0] bus_code();
        return {csbar, rasbar, casbar, webar};
    endfunction

    function automatic bit seen(input int what);
        case (what)
            EV_ACT:    return bus_code() == CMD_ACT;
            EV_READ:   return bus_code() == CMD_READ;
            EV_WRITE:  return bus_code() == CMD_WRITE;
            EV_PRE:    return bus_code() == CMD_PRE;
            EV_REF:    return bus_code() == CMD_REF;
            EV_RETURN: return put_return;
            default:   return ts;
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s %s expected %0h actual %0h", test, what, exp, act);
            errors++;
        end
    endtask

    // one clock, then the FIFO models react to the strobes of that edge
    task automatic step();
        @(posedge clk);
        #2;
        if (get_cmd) begin
            if (fetch_idx < n_cases) begin
                cmd_cmd  = case_op[fetch_idx];
                addr_cmd = case_addr[fetch_idx];
                fetch_idx++;
            end
            emptybar_cmd = (fetch_idx < n_cases);
        end
        if (get_data) begin
            wr_words.push_back(din_data);
            din_data = 16'($random(seed));
        end
        if (bus_code() == CMD_ACT && prev_bus != CMD_ACT)
            act_count++;
        prev_bus = bus_code();
    endtask

    task automatic wait_until(input int what, input int limit, input string test,
                              input string label);
        int n;
        n = 0;
        while (!seen(what) && n < limit) begin
            step();
            n++;
        end
        if (!seen(what)) begin
            $display("%s: no %s appeared within %0d cycles", test, label, limit);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_bank;
        logic [31:0] f_row;
        logic [31:0] f_col;
        fd = $fopen("verification/ddr2_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/ddr2_cases.txt");
            errors++;
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_bank, f_row, f_col);
                    if (got == 5) begin
                        case_op[n_cases]   = f_op[2:0];
                        case_addr[n_cases] = f_addr[ADDR_W-1:0];
                        case_bank[n_cases] = f_bank[BANK_W-1:0];
                        case_row[n_cases]  = f_row[ROW_W-1:0];
                        case_col[n_cases]  = f_col[9:0];
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            if (n_cases == 0) begin
                $display("the case file holds no commands");
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic end_test(input string test, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s ok", test);
        else
            $display("%s had %0d errors", test, errors - err_before);
    endtask

    // ACTIVATE then READ or WRITE, decoded from the address
    task automatic check_command(input int i, input string test, input bit is_write);
        wait_until(EV_ACT, 200, test, "ACTIVATE");
        if (!aborted) begin
            check_value(test, "activate bank", case_bank[i], ba);
            check_value(test, "activate row", case_row[i], a);
            wait_until(is_write ? EV_WRITE : EV_READ, 5, test, is_write ? "WRITE" : "READ");
        end
        if (!aborted) begin
            check_value(test, "column bank", case_bank[i], ba);
            check_value(test, "a[9:1]", case_col[i][8:0], a[9:1]);
            check_value(test, "a[10]", 1, a[10]);
            check_value(test, "a[0]", 0, a[0]);
        end
    endtask

    task automatic run_read(input int i, input string test);
        int k;
        check_command(i, test, 1'b0);
        if (!aborted)
            wait_until(EV_RETURN, 40, test, "put_return");
        if (!aborted) begin
            for (k = 0; k < BEATS; k++) begin
                check_value(test, "put_return", 1, put_return);
                check_value(test, "read_ptr", k, read_ptr);
                check_value(test, "return addr", ADDR_W'(case_addr[i] + k), addr_return);
                check_value(test, "listen", k == 0, listen);
                step();
            end
            check_value(test, "put_return after burst", 0, put_return);
        end
    endtask

    task automatic run_write(input int i, input string test);
        int              k;
        logic [DQ_W-1:0] exp_word;
        logic [1:0]      exp_dqs;
        check_command(i, test, 1'b1);
        exp_dqs = dqs;    // dqs only moves on data beats
        if (!aborted)
            wait_until(EV_DATA, 25, test, "ts");
        if (!aborted) begin
            for (k = 0; k < BEATS; k++) begin
                check_value(test, "ts", 1, ts);
                check_value(test, "get_data", 1, get_data);
                check_value(test, "dm", 0, dm);
                exp_dqs = ~exp_dqs;
                check_value(test, "dqs", exp_dqs, dqs);
                if (wr_words.size() == 0) begin
                    $display("%s: beat %0d took no word from the data FIFO", test, k);
                    errors++;
                end else begin
                    exp_word = wr_words.pop_front();
                    check_value(test, "dq", exp_word, dq);
                end
                step();
            end
            check_value(test, "ts after burst", 0, ts);
        end
    endtask

    initial begin
        int i;
        int n_valid;
        int last_valid;
        int act_before;
        int err_before;
        seed         = 8328;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        aborted      = 1'b0;
        n_cases      = 0;
        n_valid      = 0;
        last_valid   = -1;
        fetch_idx    = 0;
        act_count    = 0;
        prev_bus     = CMD_NOP;
        reset        = 1'b1;
        ready_init   = 1'b0;
        addr_cmd     = '0;
        cmd_cmd      = '0;
        emptybar_cmd = 1'b0;
        din_data     = 16'($random(seed));
        load_cases();
        repeat (2) step();
        reset = 1'b0;

        err_before = errors;
        for (i = 0; i < 3; i++) begin    // ready_init still low, nothing may move
            step();
            check_value("reset", "bus command", CMD_NOP, bus_code());
            check_value("reset", "ba", 0, ba);
            check_value("reset", "a", 0, a);
            check_value("reset", "strobes", 0, {get_cmd, get_data, put_return, listen, ts});
        end
        end_test("reset", err_before);
        ready_init   = 1'b1;
        emptybar_cmd = (n_cases > 0);

        for (i = 0; i < n_cases && !aborted; i++) begin
            err_before = errors;
            if (case_op[i] == OPC_READ) begin
                n_valid++;
                last_valid = i;
                run_read(i, $sformatf("case%0d_read", i));
                end_test($sformatf("case%0d_read", i), err_before);
            end else if (case_op[i] == OPC_WRITE) begin
                n_valid++;
                last_valid = i;
                run_write(i, $sformatf("case%0d_write", i));
                end_test($sformatf("case%0d_write", i), err_before);
            end
        end

        if (!aborted) begin
            err_before = errors;
            check_value("filter", "commands fetched", n_cases, fetch_idx);
            check_value("filter", "activates", n_valid, act_count);
            end_test("filter", err_before);
        end

        if (!aborted && last_valid >= 0) begin
            err_before = errors;
            wait_until(EV_PRE, 1000, "refresh", "PRECHARGE");
            if (!aborted) begin
                check_value("refresh", "precharge a", 13'h400, a);
                act_before = act_count;
                // a command shows up mid refresh and has to wait until it is over
                cmd_cmd      = case_op[last_valid];
                addr_cmd     = case_addr[last_valid];
                emptybar_cmd = 1'b1;
                wait_until(EV_REF, 20, "refresh", "REFRESH");
                check_value("refresh", "activates before refresh", act_before, act_count);
            end
            if (!aborted) begin
                if (case_op[last_valid] == OPC_READ)
                    run_read(last_valid, "refresh");
                else
                    run_write(last_valid, "refresh");
            end
            end_test("refresh", err_before);
        end

        if (u_ddr2_protocol_engine.u_ddr2_sequencer.u_checker.fail_count != 0) begin
            $display("bound assertions failed %0d times",
                     u_ddr2_protocol_engine.u_ddr2_sequencer.u_checker.fail_count);
            errors += u_ddr2_protocol_engine.u_ddr2_sequencer.u_checker.fail_count;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: ddr2_protocol_engine.f
design/ddr2_pkg.sv
design/dcmd_if.sv
design/cmd_fetch.sv
design/cmd_queue.sv
design/refresh_timer.sv
design/ddr2_sequencer.sv
design/ddr2_protocol_engine.sv
verification/ddr2_protocol_engine_checker.sv
verification/ddr2_protocol_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ddr2_protocol_engine_tb \
    -f ddr2_protocol_engine.f
output=$(./obj_dir/Vddr2_protocol_engine_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// File: verification/ddr2_cases.txt
# columns (hex): opcode address expected_bank expected_row expected_column
# opcode 1 is a single read, 2 a single write, anything else is dropped
1 01232B5 2 0123 0AD
2 1ABCFFF 3 1ABC 3FF
3 0456789 1 0456 1E1
1 0001808 1 0001 200
0 0000000 0 0000 000
2 0FED143 0 0FED 053
1 1FFF01E 3 1FFF 006
7 1000000 0 1000 000
2 0800672 2 0800 19A
1 0042029 1 0042 009
